/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := tb_adder_top
FILELIST  := filelist.f
OBJ_DIR   := obj_dir

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; \
	echo "$$out" | grep -q '^PASS: all tests$$'

clean:
	rm -rf $(OBJ_DIR)

/* adder_execute.sv */
`timescale 1ns/1ps

module adder_execute
   import axil_pkg::*, adder_pkg::*;
(
   input  logic          s2_axi_aclk,
   input  logic          arst_n,
   input  operand_wr_t   op_wr,
   output adder_result_t result
);

   logic [data_w-1:0] op_a;
   logic [data_w-1:0] op_b;
   logic              fresh_a;
   logic              fresh_b;
   logic [data_w:0]   full_sum;
   adder_result_t     result_q;

   // Byte lane merge under write strobes
   function automatic logic [data_w-1:0] merge_bytes(
      input logic [data_w-1:0] old_val,
      input logic [data_w-1:0] new_val,
      input logic [strb_w-1:0] strb
   );
      logic [data_w-1:0] merged;
      merged = old_val;
      for (int i = 0; i < strb_w; i++)
      begin
         if (strb[i])
         begin
            merged[8*i +: 8] = new_val[8*i +: 8];
         end
      end
      return merged;
   endfunction

   assign full_sum = {1'b0, op_a} + {1'b0, op_b};

   always_ff @(posedge s2_axi_aclk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         op_a     <= '0;
         op_b     <= '0;
         fresh_a  <= 1'b0;
         fresh_b  <= 1'b0;
         result_q <= '0;
      end
      else
      begin
         if (fresh_a && fresh_b)
         begin
            result_q.sum     <= full_sum[data_w-1:0];
            result_q.carry   <= full_sum[data_w];
            result_q.current <= 1'b1;
            fresh_a          <= 1'b0;
            fresh_b          <= 1'b0;
         end
         // A new write overrides freshness and invalidates the result
         if (op_wr.sel_a)
         begin
            op_a             <= merge_bytes(op_a, op_wr.data, op_wr.strb);
            fresh_a          <= 1'b1;
            result_q.current <= 1'b0;
         end
         if (op_wr.sel_b)
         begin
            op_b             <= merge_bytes(op_b, op_wr.data, op_wr.strb);
            fresh_b          <= 1'b1;
            result_q.current <= 1'b0;
         end
      end
   end

   assign result = result_q;

   a_result_after_fresh: assert property (@(posedge s2_axi_aclk) disable iff (!arst_n)
      $changed({result_q.sum, result_q.carry}) |-> $past(fresh_a && fresh_b));

endmodule

/* adder_pkg.sv */
package adder_pkg;

   // Register map
   localparam logic [axil_pkg::addr_w-1:0] off_op_a   = 8'h00;
   localparam logic [axil_pkg::addr_w-1:0] off_op_b   = 8'h04;
   localparam logic [axil_pkg::addr_w-1:0] off_sum    = 8'h08;
   localparam logic [axil_pkg::addr_w-1:0] off_status = 8'h0C;

   // One-cycle operand write request
   typedef struct packed
   {
      logic                          sel_a;
      logic                          sel_b;
      logic [axil_pkg::data_w-1:0]   data;
      logic [axil_pkg::strb_w-1:0]   strb;
   } operand_wr_t;

   // Registered adder output
   typedef struct packed
   {
      logic [axil_pkg::data_w-1:0]   sum;
      logic                          carry;
      logic                          current;
   } adder_result_t;

endpackage

/* adder_top.sv */
`timescale 1ns/1ps

module adder_top
   import axil_pkg::*, adder_pkg::*;
(
   input  logic                s2_axi_aclk,
   input  logic                arst_n,
   input  logic [addr_w-1:0]   s2_axi_awaddr,
   input  logic                s2_axi_awvalid,
   output logic                s2_axi_awready,
   input  logic [data_w-1:0]   s2_axi_wdata,
   input  logic [strb_w-1:0]   s2_axi_wstrb,
   input  logic                s2_axi_wvalid,
   output logic                s2_axi_wready,
   output resp_e               s2_axi_bresp,
   output logic                s2_axi_bvalid,
   input  logic                s2_axi_bready,
   input  logic [addr_w-1:0]   s2_axi_araddr,
   input  logic                s2_axi_arvalid,
   output logic                s2_axi_arready,
   output logic [data_w-1:0]   s2_axi_rdata,
   output resp_e               s2_axi_rresp,
   output logic                s2_axi_rvalid,
   input  logic                s2_axi_rready
);

   operand_wr_t   op_wr;
   adder_result_t result;

   axil_write_decode u_write_decode (
      .s2_axi_aclk (s2_axi_aclk),
      .arst_n      (arst_n),
      .awaddr      (s2_axi_awaddr),
      .awvalid     (s2_axi_awvalid),
      .awready     (s2_axi_awready),
      .wdata       (s2_axi_wdata),
      .wstrb       (s2_axi_wstrb),
      .wvalid      (s2_axi_wvalid),
      .wready      (s2_axi_wready),
      .bresp       (s2_axi_bresp),
      .bvalid      (s2_axi_bvalid),
      .bready      (s2_axi_bready),
      .op_wr       (op_wr)
   );

   adder_execute u_execute (
      .s2_axi_aclk (s2_axi_aclk),
      .arst_n      (arst_n),
      .op_wr       (op_wr),
      .result      (result)
   );

   axil_read_result u_read_result (
      .s2_axi_aclk (s2_axi_aclk),
      .arst_n      (arst_n),
      .araddr      (s2_axi_araddr),
      .arvalid     (s2_axi_arvalid),
      .arready     (s2_axi_arready),
      .rdata       (s2_axi_rdata),
      .rresp       (s2_axi_rresp),
      .rvalid      (s2_axi_rvalid),
      .rready      (s2_axi_rready),
      .result      (result)
   );

endmodule

/* axil_pkg.sv */
package axil_pkg;

   // Bus geometry
   localparam int addr_w = 8;
   localparam int data_w = 32;
   localparam int strb_w = data_w / 8;

   // Response codes returned on B and R
   typedef enum logic [1:0]
   {
      resp_okay   = 2'b00,
      resp_slverr = 2'b10
   } resp_e;

   // Write channel FSM
   typedef enum logic [1:0]
   {
      wr_idle,
      wr_accept,
      wr_resp
   } wr_state_e;

   // Read channel FSM
   typedef enum logic
   {
      rd_idle,
      rd_data
   } rd_state_e;

endpackage

/* axil_read_result.sv */
`timescale 1ns/1ps

module axil_read_result
   import axil_pkg::*, adder_pkg::*;
(
   input  logic                s2_axi_aclk,
   input  logic                arst_n,
   input  logic [addr_w-1:0]   araddr,
   input  logic                arvalid,
   output logic                arready,
   output logic [data_w-1:0]   rdata,
   output resp_e               rresp,
   output logic                rvalid,
   input  logic                rready,
   input  adder_result_t       result
);

   rd_state_e         state;
   logic              ar_xfer;
   logic [data_w-1:0] status_word;

   assign ar_xfer     = arvalid && arready;
   assign status_word = {{(data_w-2){1'b0}}, result.current, result.carry};

   always_ff @(posedge s2_axi_aclk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         state   <= rd_idle;
         arready <= 1'b1;
         rvalid  <= 1'b0;
      end
      else
      begin
         case (state)
            rd_idle:
            begin
               if (ar_xfer)
               begin
                  arready <= 1'b0;
                  rvalid  <= 1'b1;
                  state   <= rd_data;
               end
            end
            rd_data:
            begin
               // Hold the beat until the master takes it
               if (rready)
               begin
                  rvalid  <= 1'b0;
                  arready <= 1'b1;
                  state   <= rd_idle;
               end
            end
            default:
            begin
               state <= rd_idle;
            end
         endcase
      end
   end

   // Read data and response captured on the address transfer
   always_ff @(posedge s2_axi_aclk)
   begin
      if (ar_xfer)
      begin
         case (araddr)
            off_sum:
            begin
               rdata <= result.sum;
               rresp <= resp_okay;
            end
            off_status:
            begin
               rdata <= status_word;
               rresp <= resp_okay;
            end
            default:
            begin
               rdata <= '0;
               rresp <= resp_slverr;
            end
         endcase
      end
   end

   a_r_hold: assert property (@(posedge s2_axi_aclk) disable iff (!arst_n)
      rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));

endmodule

/* axil_write_decode.sv */
`timescale 1ns/1ps

module axil_write_decode
   import axil_pkg::*, adder_pkg::*;
(
   input  logic                s2_axi_aclk,
   input  logic                arst_n,
   input  logic [addr_w-1:0]   awaddr,
   input  logic                awvalid,
   output logic                awready,
   input  logic [data_w-1:0]   wdata,
   input  logic [strb_w-1:0]   wstrb,
   input  logic                wvalid,
   output logic                wready,
   output resp_e               bresp,
   output logic                bvalid,
   input  logic                bready,
   output operand_wr_t         op_wr
);

   wr_state_e state;
   logic      hit_a;
   logic      hit_b;

   // Address decode holds while the master keeps awaddr
   assign hit_a = (awaddr == off_op_a);
   assign hit_b = (awaddr == off_op_b);

   // Request is live only during the accept cycle
   assign op_wr.sel_a = (state == wr_accept) && hit_a;
   assign op_wr.sel_b = (state == wr_accept) && hit_b;
   assign op_wr.data  = wdata;
   assign op_wr.strb  = wstrb;

   always_ff @(posedge s2_axi_aclk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         state   <= wr_idle;
         awready <= 1'b0;
         wready  <= 1'b0;
         bvalid  <= 1'b0;
      end
      else
      begin
         case (state)
            wr_idle:
            begin
               // Wait for both halves of the write
               if (awvalid && wvalid)
               begin
                  awready <= 1'b1;
                  wready  <= 1'b1;
                  state   <= wr_accept;
               end
            end
            wr_accept:
            begin
               awready <= 1'b0;
               wready  <= 1'b0;
               bvalid  <= 1'b1;
               state   <= wr_resp;
            end
            wr_resp:
            begin
               if (bready)
               begin
                  bvalid <= 1'b0;
                  state  <= wr_idle;
               end
            end
            default:
            begin
               state <= wr_idle;
            end
         endcase
      end
   end

   // Response code captured at the transfer edge
   always_ff @(posedge s2_axi_aclk)
   begin
      if (state == wr_accept)
      begin
         bresp <= (hit_a || hit_b) ? resp_okay : resp_slverr;
      end
   end

   a_b_hold: assert property (@(posedge s2_axi_aclk) disable iff (!arst_n)
      bvalid && !bready |=> bvalid && $stable(bresp));

   a_ready_only_accept: assert property (@(posedge s2_axi_aclk) disable iff (!arst_n)
      (awready || wready) |-> (state == wr_accept));

   a_sel_onehot: assert property (@(posedge s2_axi_aclk) disable iff (!arst_n)
      $onehot0({op_wr.sel_a, op_wr.sel_b}));

endmodule

/* filelist.f */
axil_pkg.sv
adder_pkg.sv
axil_write_decode.sv
adder_execute.sv
axil_read_result.sv
adder_top.sv
tb_adder_top.sv

/* tb_adder_top.sv */
`timescale 1ns/1ps

module tb_adder_top
   import axil_pkg::*, adder_pkg::*;
();

   localparam int n_pairs          = 20;
   localparam int max_trans        = 125;
   localparam int cycles_per_trans = 12;
   localparam int timeout_cycles   = 2 * max_trans * cycles_per_trans;

   logic                s2_axi_aclk;
   logic                arst_n;
   logic [addr_w-1:0]   awaddr;
   logic [addr_w-1:0]   araddr;
   logic [data_w-1:0]   wdata;
   logic [data_w-1:0]   rdata;
   logic [strb_w-1:0]   wstrb;
   logic                awvalid, wvalid, bready, arvalid, rready;
   logic                awready, wready, bvalid, arready, rvalid;
   resp_e               bresp;
   resp_e               rresp;

   // Reference model state
   logic [data_w-1:0]   model_a;
   logic [data_w-1:0]   model_b;
   logic                fresh_a, fresh_b;
   adder_result_t       model_res;

   resp_e               exp_bresp;
   logic [data_w+1:0]   exp_read;
   logic [data_w+1:0]   got_read;
   logic [4:0]          ready_valid;
   logic                check_reset;
   logic [data_w-1:0]   a, b, k;
   int                  seed;
   int                  cycle_count;
   int                  value_errors;
   int                  protocol_errors;
   string               test_name;

   assign got_read    = {rresp, rdata};
   assign ready_valid = {awready, wready, bvalid, rvalid, arready};

   adder_top uut (
      .s2_axi_aclk    (s2_axi_aclk),
      .arst_n         (arst_n),
      .s2_axi_awaddr  (awaddr),
      .s2_axi_awvalid (awvalid),
      .s2_axi_awready (awready),
      .s2_axi_wdata   (wdata),
      .s2_axi_wstrb   (wstrb),
      .s2_axi_wvalid  (wvalid),
      .s2_axi_wready  (wready),
      .s2_axi_bresp   (bresp),
      .s2_axi_bvalid  (bvalid),
      .s2_axi_bready  (bready),
      .s2_axi_araddr  (araddr),
      .s2_axi_arvalid (arvalid),
      .s2_axi_arready (arready),
      .s2_axi_rdata   (rdata),
      .s2_axi_rresp   (rresp),
      .s2_axi_rvalid  (rvalid),
      .s2_axi_rready  (rready)
   );

   initial
   begin
      s2_axi_aclk = 1'b0;
      forever
      begin
         #2 s2_axi_aclk = ~s2_axi_aclk;
      end
   end

   a_reset_state: assert property (@(posedge s2_axi_aclk)
      check_reset |-> (ready_valid == 5'b00001))
   else
   begin
      $display("FAIL [%s] ready/valid after reset expected %b actual %b",
               test_name, 5'b00001, $sampled(ready_valid));
      value_errors++;
   end

   a_b_resp: assert property (@(posedge s2_axi_aclk) disable iff (!arst_n)
      (bvalid && bready) |-> (bresp == exp_bresp))
   else
   begin
      $display("FAIL [%s] bresp expected %b actual %b",
               test_name, $sampled(exp_bresp), $sampled(bresp));
      value_errors++;
   end

   // Read beat compared as {rresp, rdata}
   a_r_beat: assert property (@(posedge s2_axi_aclk) disable iff (!arst_n)
      (rvalid && rready) |-> (got_read == exp_read))
   else
   begin
      $display("FAIL [%s] read beat expected %h actual %h",
               test_name, $sampled(exp_read), $sampled(got_read));
      value_errors++;
   end

   a_b_hold: assert property (@(posedge s2_axi_aclk) disable iff (!arst_n)
      (bvalid && !bready) |=> (bvalid && $stable(bresp)))
   else
   begin
      $display("Test %s: write response dropped or changed before bready", test_name);
      protocol_errors++;
   end

   a_r_hold: assert property (@(posedge s2_axi_aclk) disable iff (!arst_n)
      (rvalid && !rready) |=> (rvalid && $stable(got_read)))
   else
   begin
      $display("Test %s: read beat dropped or changed before rready", test_name);
      protocol_errors++;
   end

   a_r_latency: assert property (@(posedge s2_axi_aclk) disable iff (!arst_n)
      (arvalid && arready) |=> rvalid)
   else
   begin
      $display("Test %s: read data did not arrive one cycle after the address", test_name);
      protocol_errors++;
   end

   function automatic void update_model(input logic [addr_w-1:0] addr,
                                        input logic [data_w-1:0] data,
                                        input logic [strb_w-1:0] strb);
      logic [data_w-1:0] mask;
      mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
      if (addr == off_op_a)
      begin
         model_a           = (model_a & ~mask) | (data & mask);
         fresh_a           = 1'b1;
         model_res.current = 1'b0;
      end
      else if (addr == off_op_b)
      begin
         model_b           = (model_b & ~mask) | (data & mask);
         fresh_b           = 1'b1;
         model_res.current = 1'b0;
      end
      if (fresh_a && fresh_b)
      begin
         // Carry out means the 32-bit sum wrapped below operand A
         model_res.sum     = model_a + model_b;
         model_res.carry   = (model_res.sum < model_a);
         model_res.current = 1'b1;
         fresh_a           = 1'b0;
         fresh_b           = 1'b0;
      end
   endfunction

   function automatic void predict_read(input logic [addr_w-1:0] addr);
      if (addr == off_sum)
      begin
         exp_read = {resp_okay, model_res.sum};
      end
      else if (addr == off_status)
      begin
         exp_read = {resp_okay, {(data_w-2){1'b0}}, model_res.current, model_res.carry};
      end
      else
      begin
         exp_read = {resp_slverr, {data_w{1'b0}}};
      end
   endfunction

   task automatic axi_write(input logic [addr_w-1:0] addr,
                            input logic [data_w-1:0] data,
                            input logic [strb_w-1:0] strb);
      int stall;
      stall     = $unsigned($random(seed)) % 4;
      exp_bresp = (addr == off_op_a || addr == off_op_b) ? resp_okay : resp_slverr;
      awaddr    = addr;
      wdata     = data;
      wstrb     = strb;
      awvalid   = 1'b1;
      wvalid    = 1'b1;
      // Both readies show one cycle after both valids and the transfer follows
      do
      begin
         @(negedge s2_axi_aclk);
      end
      while (!(awready && wready));
      @(negedge s2_axi_aclk);
      awvalid = 1'b0;
      wvalid  = 1'b0;
      repeat (stall) @(negedge s2_axi_aclk);
      while (!bvalid)
      begin
         @(negedge s2_axi_aclk);
      end
      bready = 1'b1;
      @(negedge s2_axi_aclk);
      bready = 1'b0;
      update_model(addr, data, strb);
   endtask

   task automatic axi_read(input logic [addr_w-1:0] addr);
      int stall;
      stall   = $unsigned($random(seed)) % 4;
      predict_read(addr);
      araddr  = addr;
      arvalid = 1'b1;
      while (!arready)
      begin
         @(negedge s2_axi_aclk);
      end
      @(negedge s2_axi_aclk);
      arvalid = 1'b0;
      repeat (stall) @(negedge s2_axi_aclk);
      rready = 1'b1;
      @(negedge s2_axi_aclk);
      rready = 1'b0;
   endtask

   initial
   begin
      seed            = 32'hb570;
      value_errors    = 0;
      protocol_errors = 0;
      {awaddr, wdata, wstrb, awvalid, wvalid, bready} = '0;
      {araddr, arvalid, rready} = '0;
      {model_a, model_b, fresh_a, fresh_b, model_res} = '0;
      exp_bresp   = resp_okay;
      exp_read    = '0;
      check_reset = 1'b0;
      test_name   = "reset";
      arst_n      = 1'b0;
      repeat (2) @(negedge s2_axi_aclk);
      arst_n = 1'b1;
      @(negedge s2_axi_aclk);
      check_reset = 1'b1;
      @(negedge s2_axi_aclk);
      check_reset = 1'b0;
      axi_read(off_status);

      test_name = "random_pairs";
      for (int i = 0; i < n_pairs; i++)
      begin
         a = $random(seed);
         b = $random(seed);
         // Every fourth pair is forced to carry out
         if (i % 4 == 0)
         begin
            k = $unsigned($random(seed)) % 16;
            b = 32'hffff_ffff - a + k + 1;
         end
         axi_write(off_op_a, a, 4'hf);
         axi_write(off_op_b, b, 4'hf);
         axi_read(off_sum);
         axi_read(off_status);
      end

      test_name = "partial_strobes";
      axi_write(off_op_a, 32'h1122_3344, 4'hf);
      axi_write(off_op_b, 32'h0101_0101, 4'hf);
      axi_write(off_op_a, 32'haabb_ccdd, 4'b0101);
      axi_write(off_op_b, 32'hf000_0000, 4'b1000);
      axi_read(off_sum);
      axi_write(off_op_b, 32'h0000_ff00, 4'b0010);
      axi_write(off_op_a, 32'h8800_0000, 4'b1100);
      axi_read(off_sum);
      axi_read(off_status);

      test_name = "single_rewrite";
      axi_write(off_op_a, $random(seed), 4'hf);
      axi_read(off_sum);
      axi_read(off_status);
      axi_write(off_op_b, $random(seed), 4'hf);
      axi_read(off_sum);
      axi_read(off_status);

      test_name = "unmapped";
      axi_write(8'h10, 32'hdead_beef, 4'hf);
      axi_write(8'h4c, 32'h1234_5678, 4'hf);
      axi_write(off_sum, 32'hffff_ffff, 4'hf);
      axi_read(8'h10);
      axi_read(8'h4c);
      axi_read(off_op_a);
      axi_read(off_sum);
      axi_read(off_status);

      repeat (4) @(negedge s2_axi_aclk);
      $display("Errors: %0d value, %0d protocol", value_errors, protocol_errors);
      if (value_errors + protocol_errors == 0)
      begin
         $display("PASS: all tests");
      end
      else
      begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

   initial
   begin
      cycle_count = 0;
      while (cycle_count < timeout_cycles)
      begin
         @(posedge s2_axi_aclk);
         cycle_count++;
      end
      $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
      $display("FAIL: see errors above");
      $finish;
   end

endmodule
